// File: design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    typedef logic [22:0] sdram_addr_t;      // SDRAM word address
    typedef logic [15:0] word_t;
    typedef logic [31:0] gfx_t;             // First word in the low half

    // Bank port toward the controller
    typedef struct packed {
        sdram_addr_t addr;
        logic        rd;
        logic        wr;
        word_t       din;
        logic [1:0]  wrmask;                // 1 keeps the byte
    } bank_req_t;

    // Controller answer, one ack per request
    typedef struct packed {
        logic  ack;
        logic  dst;                         // Data on the bus this cycle
        logic  rdy;                         // Request finished
        word_t data;
    } bank_rsp_t;

    // What a slot hands to its bank arbiter
    typedef struct packed {
        logic        req;
        logic        we;
        sdram_addr_t addr;                  // Already offset into the map
        word_t       din;
        logic [1:0]  wrmask;
    } slot_req_t;

    // Region offsets, in words
    localparam sdram_addr_t ROM_OFFSET  = 23'h00_0000;
    localparam sdram_addr_t WRAM_OFFSET = 23'h30_0000;
    localparam sdram_addr_t GFX_OFFSET  = 23'h00_0000;  // Bank 1

    // Download byte address where graphics data begins
    localparam logic [25:0] DL_GFX_START = 26'h040_0000;

    // Slots per bank
    localparam int NSLOT  = 2;
    localparam int SLOT_W = $clog2(NSLOT);

endpackage

`default_nettype wire

// File: design/sdram_slot.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_slot
    import sdram_pkg::*;
#(
    parameter type data_t = word_t,
    parameter bit  DOUBLE = 1'b0            // Payload spans two words
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        cs,
    input  wire sdram_addr_t addr,
    input  wire sdram_addr_t offset,
    input  wire logic        we,
    input  wire word_t       din,
    input  wire logic [1:0]  wrmask,
    input  wire logic        clr,
    input  wire logic        gnt,
    input  wire bank_rsp_t   rsp,
    output slot_req_t        req,
    output logic             ok,
    output data_t            dout
);
    sdram_addr_t caddr;                     // Client address of cached data
    data_t       cdata;
    logic        valid;
    logic        busy;
    logic        part;                      // Second word of a pair
    logic        wr_done;
    sdram_addr_t op_addr;
    logic        op_we;
    word_t       op_din;
    logic [1:0]  op_mask;
    sdram_addr_t sd_addr;
    word_t       rd_word;
    word_t       lo_word;
    word_t       cur_word;
    data_t       fill;
    data_t       merged;
    logic        hit;
    logic        wr_held;
    logic        start;
    logic        done;
    logic        last;

    assign hit      = valid && caddr == addr;
    assign wr_held  = wr_done && addr == op_addr;   // Finished write still presented
    assign start    = !busy && cs && (we ? !wr_held : !hit);
    assign done     = gnt && rsp.rdy;
    assign last     = !DOUBLE || op_we || part;
    assign cur_word = (gnt && rsp.dst) ? rsp.data : rd_word;
    assign dout     = cdata;

    generate
        if (DOUBLE) begin : g_double
            assign fill = {cur_word, lo_word};
        end else begin : g_single
            assign fill = cur_word;
        end
    endgenerate

    // Write data merged into a cached word
    always_comb begin
        merged = cdata;
        if (!op_mask[1]) merged[15:8] = op_din[15:8];
        if (!op_mask[0]) merged[7:0] = op_din[7:0];
    end

    always_comb begin
        req.req    = busy;
        req.we     = op_we;
        req.addr   = sd_addr;
        req.din    = op_din;
        req.wrmask = op_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= 1'b0;
            busy    <= 1'b0;
            part    <= 1'b0;
            wr_done <= 1'b0;
            ok      <= 1'b0;
        end else begin
            ok <= (cs && (we ? wr_held : hit)) || (busy && done && last);
            if (!cs || !we || addr != op_addr) wr_done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                part <= 1'b0;
            end
            if (busy && done) begin
                if (last) begin
                    busy <= 1'b0;
                    if (op_we) wr_done <= 1'b1;
                    else valid <= 1'b1;
                end else begin
                    part <= 1'b1;               // Go fetch the upper word
                end
            end
            if (clr) valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_addr <= addr;
            op_we   <= we;
            op_din  <= din;
            op_mask <= wrmask;
            sd_addr <= offset + addr;
        end
        if (gnt && rsp.dst) rd_word <= rsp.data;
        if (busy && done && !last) begin
            lo_word <= cur_word;
            sd_addr <= sd_addr + 1'b1;
        end
        if (busy && done && last) begin
            if (!op_we) begin
                caddr <= op_addr;
                cdata <= fill;
            end else if (valid && caddr == op_addr) begin
                cdata <= merged;                // Write hit keeps cache coherent
            end
        end
    end

endmodule

`default_nettype wire

// File: design/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter
    import sdram_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire slot_req_t [NSLOT-1:0] slot_req,
    input  wire bank_rsp_t             bank_rsp,
    output logic [NSLOT-1:0]           gnt,
    output bank_req_t                  bank_req,
    output bank_rsp_t [NSLOT-1:0]      slot_rsp
);
    logic              busy;
    logic              pending;             // rd or wr up, waiting for ack
    logic [SLOT_W-1:0] sel;
    logic [SLOT_W-1:0] last;                // Last slot served
    logic [SLOT_W-1:0] pick;
    logic [NSLOT-1:0]  waiting;
    slot_req_t         cur;

    always_comb begin
        for (int i = 0; i < NSLOT; i++) begin
            waiting[i] = slot_req[i].req;
        end
    end

    // Nearest requester after the last one wins
    always_comb begin
        int idx;
        pick = last;
        for (int k = NSLOT; k >= 1; k--) begin
            idx = (int'(last) + k) % NSLOT;
            if (waiting[idx]) pick = SLOT_W'(idx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            sel     <= '0;
            last    <= '0;
        end else if (!busy) begin
            if (|waiting) begin
                busy    <= 1'b1;
                pending <= 1'b1;
                sel     <= pick;
            end
        end else begin
            if (bank_rsp.ack) pending <= 1'b0;  // Issue exactly once
            if (bank_rsp.rdy) begin
                busy    <= 1'b0;
                pending <= 1'b0;
                last    <= sel;
            end
        end
    end

    assign cur = slot_req[sel];

    always_comb begin
        bank_req.addr   = cur.addr;
        bank_req.din    = cur.din;
        bank_req.wrmask = cur.wrmask;
        bank_req.rd     = pending && !cur.we;
        bank_req.wr     = pending && cur.we;
    end

    always_comb begin
        for (int i = 0; i < NSLOT; i++) begin
            gnt[i] = busy && sel == SLOT_W'(i);
        end
    end

    // Handshake strobes only reach the granted slot
    always_comb begin
        for (int i = 0; i < NSLOT; i++) begin
            slot_rsp[i]      = bank_rsp;
            slot_rsp[i].ack  = bank_rsp.ack && gnt[i];
            slot_rsp[i].dst  = bank_rsp.dst && gnt[i];
            slot_rsp[i].rdy  = bank_rsp.rdy && gnt[i];
        end
    end

endmodule

`default_nettype wire

// File: design/rom_download.sv
`timescale 1ns/1ps
`default_nettype none

module rom_download
    import sdram_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        downloading,
    input  wire logic [25:0] ioctl_addr,
    input  wire logic [ 7:0] ioctl_dout,
    input  wire logic        ioctl_wr,
    input  wire logic        prog_rdy,
    output sdram_addr_t      prog_addr,
    output word_t            prog_data,
    output logic [1:0]       prog_mask,
    output logic             prog_ba,
    output logic             prog_we,
    output logic             dwnld_busy
);
    logic        is_gfx;
    logic [25:0] rel_addr;                  // Byte address inside its region
    sdram_addr_t word_addr;
    logic        strobe;

    assign is_gfx    = ioctl_addr >= DL_GFX_START;
    assign rel_addr  = is_gfx ? ioctl_addr - DL_GFX_START : ioctl_addr;
    assign word_addr = (is_gfx ? GFX_OFFSET : ROM_OFFSET) + rel_addr[23:1];
    assign strobe    = downloading && ioctl_wr;

    // Write request held until the controller takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else begin
            if (prog_rdy) prog_we <= 1'b0;
            if (strobe) prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            prog_addr <= word_addr;
            prog_data <= {ioctl_dout, ioctl_dout};
            prog_ba   <= is_gfx;                // Graphics go to bank 1
            // Even byte lands in the upper half, big-endian CPU order
            prog_mask <= rel_addr[0] ? 2'b10 : 2'b01;
        end
    end

    assign dwnld_busy = downloading || prog_we;

endmodule

`default_nettype wire

// File: design/game_sdram.sv
`timescale 1ns/1ps
`default_nettype none

module game_sdram
    import sdram_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic        downloading,
    input  wire logic [25:0] ioctl_addr,
    input  wire logic [ 7:0] ioctl_dout,
    input  wire logic        ioctl_wr,
    input  wire logic        prog_rdy,
    output sdram_addr_t      prog_addr,
    output word_t            prog_data,
    output logic [1:0]       prog_mask,
    output logic             prog_ba,
    output logic             prog_we,
    output logic             dwnld_busy,

    // Main CPU
    input  wire logic        main_ram_cs,
    input  wire logic [16:0] main_ram_addr,
    input  wire logic        main_rnw,
    input  wire word_t       main_dout,
    input  wire logic [1:0]  dsn,
    output logic             main_ram_ok,
    output word_t            main_ram_data,
    input  wire logic        main_rom_cs,
    input  wire logic [20:0] main_rom_addr,
    output logic             main_rom_ok,
    output word_t            main_rom_data,

    // Graphics
    input  wire logic        obj_cs,
    input  wire logic [21:0] obj_addr,
    input  wire logic        obj_clr,
    output logic             obj_ok,
    output gfx_t             obj_data,
    input  wire logic        scr_cs,
    input  wire logic [21:0] scr_addr,
    output logic             scr_ok,
    output gfx_t             scr_data,

    // Bank ports
    output bank_req_t        ba0_req,
    input  wire bank_rsp_t   ba0_rsp,
    output bank_req_t        ba1_req,
    input  wire bank_rsp_t   ba1_rsp
);
    wire slot_req_t [NSLOT-1:0] ba0_slot_req;
    wire slot_req_t [NSLOT-1:0] ba1_slot_req;
    wire bank_rsp_t [NSLOT-1:0] ba0_slot_rsp;
    wire bank_rsp_t [NSLOT-1:0] ba1_slot_rsp;
    wire logic      [NSLOT-1:0] ba0_gnt;
    wire logic      [NSLOT-1:0] ba1_gnt;

    rom_download u_download (
        .clk(clk), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .prog_rdy(prog_rdy), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_ba(prog_ba), .prog_we(prog_we),
        .dwnld_busy(dwnld_busy)
    );

    // Bank 0, work RAM in slot 0 and CPU ROM in slot 1
    sdram_slot #(.data_t(word_t), .DOUBLE(1'b0)) u_ram_slot (
        .clk(clk), .rst(rst), .cs(main_ram_cs), .addr({6'd0, main_ram_addr}),
        .offset(WRAM_OFFSET), .we(!main_rnw), .din(main_dout), .wrmask(dsn),
        .clr(1'b0), .gnt(ba0_gnt[0]), .rsp(ba0_slot_rsp[0]),
        .req(ba0_slot_req[0]), .ok(main_ram_ok), .dout(main_ram_data)
    );

    sdram_slot #(.data_t(word_t), .DOUBLE(1'b0)) u_rom_slot (
        .clk(clk), .rst(rst), .cs(main_rom_cs), .addr({2'd0, main_rom_addr}),
        .offset(ROM_OFFSET), .we(1'b0), .din('0), .wrmask(2'b11),
        .clr(1'b0), .gnt(ba0_gnt[1]), .rsp(ba0_slot_rsp[1]),
        .req(ba0_slot_req[1]), .ok(main_rom_ok), .dout(main_rom_data)
    );

    bank_arbiter u_bank0 (
        .clk(clk), .rst(rst), .slot_req(ba0_slot_req), .bank_rsp(ba0_rsp),
        .gnt(ba0_gnt), .bank_req(ba0_req), .slot_rsp(ba0_slot_rsp)
    );

    // Bank 1 is read only, both slots fetch word pairs
    sdram_slot #(.data_t(gfx_t), .DOUBLE(1'b1)) u_obj_slot (
        .clk(clk), .rst(rst), .cs(obj_cs), .addr({1'b0, obj_addr}),
        .offset(GFX_OFFSET), .we(1'b0), .din('0), .wrmask(2'b11),
        .clr(obj_clr), .gnt(ba1_gnt[0]), .rsp(ba1_slot_rsp[0]),
        .req(ba1_slot_req[0]), .ok(obj_ok), .dout(obj_data)
    );

    sdram_slot #(.data_t(gfx_t), .DOUBLE(1'b1)) u_scr_slot (
        .clk(clk), .rst(rst), .cs(scr_cs), .addr({1'b0, scr_addr}),
        .offset(GFX_OFFSET), .we(1'b0), .din('0), .wrmask(2'b11),
        .clr(1'b0), .gnt(ba1_gnt[1]), .rsp(ba1_slot_rsp[1]),
        .req(ba1_slot_req[1]), .ok(scr_ok), .dout(scr_data)
    );

    bank_arbiter u_bank1 (
        .clk(clk), .rst(rst), .slot_req(ba1_slot_req), .bank_rsp(ba1_rsp),
        .gnt(ba1_gnt), .bank_req(ba1_req), .slot_rsp(ba1_slot_rsp)
    );

endmodule

`default_nettype wire

// File: sim/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model
    import sdram_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire bank_req_t   ba0_req,
    output bank_rsp_t        ba0_rsp,
    input  wire bank_req_t   ba1_req,
    output bank_rsp_t        ba1_rsp,
    input  wire logic        downloading,
    input  wire sdram_addr_t prog_addr,
    input  wire word_t       prog_data,
    input  wire logic [1:0]  prog_mask,
    input  wire logic        prog_ba,
    input  wire logic        prog_we,
    output logic             prog_rdy
);
    typedef enum int {IDLE, ACK, DATA, DONE} chan_state_t;

    word_t       mem [2][65536];            // Map folded into 64K words per bank
    bank_req_t   req [2];
    bank_req_t   op [2];                    // Request latched at acceptance
    bank_rsp_t   rsp [2];
    chan_state_t state [2];
    int          cnt [2];
    int          prog_cnt;
    integer      seed;

    assign req[0]  = ba0_req;
    assign req[1]  = ba1_req;
    assign ba0_rsp = rsp[0];
    assign ba1_rsp = rsp[1];

    // Work RAM sits at bit 21, ROM and graphics in the low words
    function automatic int widx(sdram_addr_t a);
        return {a[21], a[14:0]};
    endfunction

    function automatic int pick_delay();
        return 1 + int'($unsigned($random(seed)) % 4);
    endfunction

    // A set mask bit keeps the old byte
    task automatic write_word(int b, sdram_addr_t a, word_t d, logic [1:0] m);
        if (!m[1]) mem[b][widx(a)][15:8] = d[15:8];
        if (!m[0]) mem[b][widx(a)][7:0] = d[7:0];
    endtask

    initial begin
        seed = 79;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 65536; i++) begin
                mem[b][i] = 16'(i) ^ (b == 0 ? 16'hc35a : 16'h5ac3);
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < 2; b++) begin
                state[b] <= IDLE;
                rsp[b]   <= '0;
            end
            prog_cnt <= 0;
            prog_rdy <= 1'b0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                rsp[b].ack <= 1'b0;
                rsp[b].dst <= 1'b0;
                rsp[b].rdy <= 1'b0;
                case (state[b])
                    IDLE: begin
                        // Programming writes go first
                        if ((req[b].rd || req[b].wr) && !(downloading && prog_we)) begin
                            op[b]    <= req[b];
                            cnt[b]   <= pick_delay();
                            state[b] <= ACK;
                        end
                    end
                    ACK: begin
                        if (cnt[b] > 1) begin
                            cnt[b] <= cnt[b] - 1;
                        end else begin
                            rsp[b].ack <= 1'b1;
                            cnt[b]     <= pick_delay();
                            state[b]   <= DATA;
                        end
                    end
                    DATA: begin
                        if (cnt[b] > 1) begin
                            cnt[b] <= cnt[b] - 1;
                        end else if (op[b].wr) begin
                            write_word(b, op[b].addr, op[b].din, op[b].wrmask);
                            rsp[b].rdy <= 1'b1;         // No data phase on writes
                            state[b]   <= IDLE;
                        end else begin
                            rsp[b].dst  <= 1'b1;
                            rsp[b].data <= mem[b][widx(op[b].addr)];
                            state[b]    <= DONE;
                        end
                    end
                    DONE: begin
                        rsp[b].rdy <= 1'b1;
                        state[b]   <= IDLE;
                    end
                endcase
            end
            prog_rdy <= 1'b0;
            if (prog_cnt == 0) begin
                if (downloading && prog_we && !prog_rdy) prog_cnt <= pick_delay();
            end else if (prog_cnt == 1) begin
                write_word(int'(prog_ba), prog_addr, prog_data, prog_mask);
                prog_rdy <= 1'b1;
                prog_cnt <= 0;
            end else begin
                prog_cnt <= prog_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/game_sdram_chk.sv
`timescale 1ns/1ps
`default_nettype none

module game_sdram_chk
    import sdram_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [NSLOT-1:0] gnt,
    input  wire bank_req_t        bank_req,
    input  wire bank_rsp_t        bank_rsp
);
    int fail_count;                         // Assertion failures so far

    initial fail_count = 0;

    one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else begin
            $error("more than one grant bit set");
            fail_count++;
        end

    rd_held: assert property (@(posedge clk) disable iff (rst)
        (bank_req.rd && !bank_rsp.ack) |=> (bank_req.rd && $stable(bank_req.addr)))
        else begin
            $error("rd dropped or address moved before ack");
            fail_count++;
        end

    wr_held: assert property (@(posedge clk) disable iff (rst)
        (bank_req.wr && !bank_rsp.ack) |=>
        (bank_req.wr && $stable(bank_req.addr) && $stable(bank_req.din)))
        else begin
            $error("wr dropped or address moved before ack");
            fail_count++;
        end

    rd_wr_apart: assert property (@(posedge clk) disable iff (rst)
        !(bank_req.rd && bank_req.wr))
        else begin
            $error("rd and wr high together");
            fail_count++;
        end

    ack_on_req: assert property (@(posedge clk) disable iff (rst)
        bank_rsp.ack |-> (bank_req.rd || bank_req.wr))
        else begin
            $error("ack without a pending request");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: sim/game_sdram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_sdram_tb
    import sdram_pkg::*;
();
    logic        clk;
    logic        rst;
    logic        downloading;
    logic [25:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        prog_rdy;
    sdram_addr_t prog_addr;
    word_t       prog_data;
    logic [1:0]  prog_mask;
    logic        prog_ba;
    logic        prog_we;
    logic        dwnld_busy;
    logic        main_ram_cs;
    logic [16:0] main_ram_addr;
    logic        main_rnw;
    word_t       main_dout;
    logic [1:0]  dsn;
    logic        main_ram_ok;
    word_t       main_ram_data;
    logic        main_rom_cs;
    logic [20:0] main_rom_addr;
    logic        main_rom_ok;
    word_t       main_rom_data;
    logic        obj_cs;
    logic [21:0] obj_addr;
    logic        obj_clr;
    logic        obj_ok;
    gfx_t        obj_data;
    logic        scr_cs;
    logic [21:0] scr_addr;
    logic        scr_ok;
    gfx_t        scr_data;
    bank_req_t   ba0_req;
    bank_req_t   ba1_req;
    bank_rsp_t   ba0_rsp;
    bank_rsp_t   ba1_rsp;
    logic [7:0]  rom_img [256];             // Downloaded bytes, in download order
    logic [7:0]  gfx_img [256];
    word_t       ram_ref [16];
    integer      seed;
    int          cycles;
    int          ba1_rd_cycles;             // Cycles with a bank 1 read up
    int          rd_before;

    game_sdram uut (.*);
    sdram_model u_model (.*);

    bind bank_arbiter game_sdram_chk u_chk (
        .clk(clk), .rst(rst), .gnt(gnt), .bank_req(bank_req), .bank_rsp(bank_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (ba1_req.rd) ba1_rd_cycles <= ba1_rd_cycles + 1;
        if (uut.u_bank0.u_chk.fail_count + uut.u_bank1.u_chk.fail_count != 0) begin
            $display("protocol assertion failed on a bank port");
            $display("sim failed");
            $fatal(1, "protocol violation");
        end else if (cycles >= 20000) begin
            $display("run stopped after %0d cycles, tests did not finish", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_check(string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "data check");
    endtask

    // Big-endian pair, even byte on top
    function automatic word_t gfx_word(int k);
        return {gfx_img[2*k], gfx_img[2*k+1]};
    endfunction

    task automatic download_byte(logic [25:0] a, logic [7:0] d);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        assert (prog_we) else fail_check("prog_we did not rise after ioctl_wr");
        while (prog_we) @(negedge clk);
    endtask

    task automatic rom_read(int a);
        word_t exp;
        exp = {rom_img[2*a], rom_img[2*a+1]};
        @(negedge clk);
        main_rom_cs   = 1'b1;
        main_rom_addr = 21'(a);
        do @(negedge clk); while (!main_rom_ok);
        assert (main_rom_data == exp)
            else fail_check($sformatf("ROM word %0d gave %h, expected %h", a, main_rom_data, exp));
        main_rom_cs = 1'b0;
    endtask

    task automatic ram_write(int a, word_t d, logic [1:0] m);
        @(negedge clk);
        main_ram_cs   = 1'b1;
        main_ram_addr = 17'(a);
        main_rnw      = 1'b0;
        main_dout     = d;
        dsn           = m;
        do @(negedge clk); while (!main_ram_ok);
        if (!m[1]) ram_ref[a][15:8] = d[15:8];     // dsn low writes the byte
        if (!m[0]) ram_ref[a][7:0] = d[7:0];
        main_ram_cs = 1'b0;
        main_rnw    = 1'b1;
        dsn         = 2'b11;
    endtask

    task automatic ram_read(int a);
        @(negedge clk);
        main_ram_cs   = 1'b1;
        main_ram_addr = 17'(a);
        main_rnw      = 1'b1;
        do @(negedge clk); while (!main_ram_ok);
        assert (main_ram_data == ram_ref[a])
            else fail_check($sformatf("RAM word %0d gave %h, expected %h",
                                      a, main_ram_data, ram_ref[a]));
        main_ram_cs = 1'b0;
    endtask

    task automatic obj_read(int a);
        gfx_t exp;
        exp = {gfx_word(a + 1), gfx_word(a)};
        @(negedge clk);
        obj_cs   = 1'b1;
        obj_addr = 22'(a);
        do @(negedge clk); while (!obj_ok);
        assert (obj_data == exp)
            else fail_check($sformatf("obj word %0d gave %h, expected %h", a, obj_data, exp));
        obj_cs = 1'b0;
    endtask

    task automatic scr_read(int a);
        gfx_t exp;
        exp = {gfx_word(a + 1), gfx_word(a)};
        @(negedge clk);
        scr_cs   = 1'b1;
        scr_addr = 22'(a);
        do @(negedge clk); while (!scr_ok);
        assert (scr_data == exp)
            else fail_check($sformatf("scr word %0d gave %h, expected %h", a, scr_data, exp));
        scr_cs = 1'b0;
    endtask

    initial begin
        seed          = 79;
        cycles        = 0;
        ba1_rd_cycles = 0;
        rst           = 1'b1;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_dout    = '0;
        ioctl_wr      = 1'b0;
        main_ram_cs   = 1'b0;
        main_ram_addr = '0;
        main_rnw      = 1'b1;
        main_dout     = '0;
        dsn           = 2'b11;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        obj_cs        = 1'b0;
        obj_addr      = '0;
        obj_clr       = 1'b0;
        scr_cs        = 1'b0;
        scr_addr      = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        assert (!main_ram_ok && !main_rom_ok && !obj_ok && !scr_ok && !prog_we && !dwnld_busy
                && !ba0_req.rd && !ba0_req.wr && !ba1_req.rd)
            else fail_check("outputs not idle after reset");

        // Download both regions
        for (int i = 0; i < 256; i++) begin
            rom_img[i] = 8'($random(seed));
            gfx_img[i] = 8'($random(seed));
        end
        downloading = 1'b1;
        for (int i = 0; i < 256; i++) download_byte(26'(i), rom_img[i]);
        for (int i = 0; i < 256; i++) download_byte(DL_GFX_START + 26'(i), gfx_img[i]);
        assert (dwnld_busy) else fail_check("dwnld_busy low during download");
        @(negedge clk);
        downloading = 1'b0;
        @(negedge clk);
        assert (!dwnld_busy) else fail_check("dwnld_busy stuck after download");

        for (int i = 0; i < 8; i++) rom_read(int'($unsigned($random(seed)) % 128));
        obj_read(0);
        scr_read(126);

        // Masked writes, through the cache and through memory
        ram_write(5, 16'h1234, 2'b00);
        ram_read(5);
        ram_write(5, 16'hab00, 2'b01);
        ram_read(5);
        ram_write(9, 16'h5a5a, 2'b00);
        ram_read(9);
        ram_write(5, 16'h00cd, 2'b10);
        ram_read(5);

        // Hit answers in one cycle with no bank traffic
        obj_read(10);
        rd_before = ba1_rd_cycles;
        @(negedge clk);
        assert (!obj_ok) else fail_check("obj_ok high with cs low");
        obj_cs   = 1'b1;
        obj_addr = 22'd10;
        @(negedge clk);
        assert (obj_ok && obj_data == {gfx_word(11), gfx_word(10)})
            else fail_check("cache hit not answered one cycle after cs");
        repeat (3) @(negedge clk);          // Time for a request to reach bank 1
        assert (ba1_rd_cycles == rd_before) else fail_check("cache hit raised a bank 1 read");
        obj_cs = 1'b0;
        @(negedge clk);
        obj_clr = 1'b1;
        @(negedge clk);
        obj_clr = 1'b0;
        obj_read(10);
        assert (ba1_rd_cycles > rd_before) else fail_check("read after obj_clr used the cache");

        // Both slots of a bank at once
        fork
            rom_read(3);
            ram_read(5);
        join
        fork
            obj_read(40);
            scr_read(41);
        join
        fork
            rom_read(77);
            ram_read(9);
            obj_read(63);
            scr_read(100);
        join

        repeat (4) @(negedge clk);
        if (uut.u_bank0.u_chk.fail_count + uut.u_bank1.u_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: game_sdram.f
design/sdram_pkg.sv
design/sdram_slot.sv
design/bank_arbiter.sv
design/rom_download.sv
design/game_sdram.sv
sim/sdram_model.sv
sim/game_sdram_chk.sv
sim/game_sdram_tb.sv
